// ==== verilog.f ====
rtl/sparc_pkg.sv
rtl/sparc_ifs.sv
rtl/instr_decoder.sv
rtl/branch_cond.sv
rtl/control_sequencer.sv
rtl/sparc_datapath.sv
rtl/sparc_core.sv
dv/sparc_core_assertions.sv
dv/tb_sparc_core.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_sparc_core
FILELIST = verilog.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tb_sparc_core.sv ====
`timescale 1ns/1ps

module tb_sparc_core;

	localparam logic [31:0] RESET_PC = 32'h0000_1000;
	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 4;
	localparam int N_RANDOM     = 128;  // Random mix ahead of 32 directed branches
	localparam int N_BUDGET     = 200;  // Instructions the watchdog allows for
	localparam int MAX_CYCLES   = 4;    // Worst case per instruction from offer to check

	logic Clk;
	logic RESET;
	logic [31:0] instr;
	logic instr_valid;
	logic [4:0] dbg_addr;
	logic busy;
	logic [31:0] pc;
	logic [31:0] npc;
	logic [3:0] icc;
	logic [31:0] dbg_data;

	// Reference model state
	logic [31:0] m_regs [32];
	logic [31:0] m_pc;
	logic [31:0] m_npc;
	logic [3:0] m_icc;  // n z v c
	logic [31:0] lfsr;

	sparc_core #(.RESET_PC(RESET_PC)) DUT (
		.Clk(Clk),
		.RESET(RESET),
		.instr(instr),
		.instr_valid(instr_valid),
		.dbg_addr(dbg_addr),
		.busy(busy),
		.pc(pc),
		.npc(npc),
		.icc(icc),
		.dbg_data(dbg_data)
	);

	initial Clk = 1'b0;
	always #(CLK_PERIOD / 2) Clk = ~Clk;

	initial begin
		#(RESET_CYCLES * CLK_PERIOD + N_BUDGET * MAX_CYCLES * CLK_PERIOD);
		$display("Timeout: the core did not finish its instructions in time");
		$display("Test failed");
		$fatal(1);
	end

	// Galois LFSR with one shift per bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic [31:0] sext13(input logic [12:0] s);
		return {{19{s[12]}}, s};
	endfunction

	// Second operand as the model sees it
	function automatic logic [31:0] operand2(input logic imm, input logic [12:0] simm,
		input logic [4:0] rs2);
		return imm ? sext13(simm) : m_regs[rs2];
	endfunction

	// Bicc table from n z v c
	function automatic logic cond_holds(input logic [3:0] cond, input logic [3:0] f);
		logic n, z, v, c;
		{n, z, v, c} = f;
		case (cond)
			4'h0: return 1'b0;              // BN
			4'h1: return z;                 // BE
			4'h2: return z | (n ^ v);       // BLE
			4'h3: return n ^ v;             // BL
			4'h4: return c | z;             // BLEU
			4'h5: return c;                 // BCS
			4'h6: return n;                 // BNEG
			4'h7: return v;                 // BVS
			4'h8: return 1'b1;              // BA
			4'h9: return !z;                // BNE
			4'ha: return !(z | (n ^ v));    // BG
			4'hb: return !(n ^ v);          // BGE
			4'hc: return !(c | z);          // BGU
			4'hd: return !c;                // BCC
			4'he: return !n;                // BPOS
			default: return !v;             // BVC
		endcase
	endfunction

	// Function code fn is op3[2:0] with ADD 0 AND 1 OR 2 XOR 3 SUB 4
	task automatic model_alu(input logic [2:0] fn, input logic [31:0] a, input logic [31:0] b,
		output logic [31:0] res, output logic [3:0] flags);
		logic [32:0] wide;
		logic v, c;
		v = 1'b0;  // Logical ops leave v and c clear
		c = 1'b0;
		case (fn)
			3'd0: begin
				wide = {1'b0, a} + {1'b0, b};
				res = wide[31:0];
				c = wide[32];
				v = (a[31] & b[31] & !res[31]) | (!a[31] & !b[31] & res[31]);
			end
			3'd4: begin
				res = a - b;
				c = (a < b);  // Borrow
				v = (a[31] & !b[31] & !res[31]) | (!a[31] & b[31] & res[31]);
			end
			3'd1: res = a & b;
			3'd2: res = a | b;
			default: res = a ^ b;
		endcase
		flags = {res[31], res == 32'd0, v, c};
	endtask

	task automatic write_reg(input logic [4:0] rd, input logic [31:0] val);
		if (rd != 5'd0)
			m_regs[rd] = val;  // r0 stays zero
	endtask

	task automatic advance();
		m_pc = m_npc;
		m_npc = m_npc + 32'd4;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH at %0d ns: %s is %h, expected %h", $time, name, got, exp);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic check_state();
		check_value("pc", pc, m_pc);
		check_value("npc", npc, m_npc);
		check_value("icc", {28'd0, icc}, {28'd0, m_icc});
		check_value($sformatf("r%0d", dbg_addr), dbg_data, m_regs[dbg_addr]);
	endtask

	// Offer one word and strobe junk while busy before waiting for busy to drop
	task automatic issue(input logic [31:0] word, input logic [4:0] addr);
		logic [31:0] junk;
		@(negedge Clk);
		instr = word;
		instr_valid = 1'b1;
		dbg_addr = addr;  // Register to read back when done
		@(negedge Clk);
		junk = rand_bits(32);
		instr = junk;
		instr_valid = junk[0];  // Core is busy so this strobe must be dropped
		@(negedge Clk);
		instr_valid = 1'b0;
		while (busy)
			@(negedge Clk);
	endtask

	task automatic do_alu();
		logic [31:0] fn, cc, imm, rd, rs1, rs2, simm, res;
		logic [3:0] flags;
		fn = rand_bits(3) % 5;
		cc = rand_bits(1);
		imm = rand_bits(1);
		rd = rand_bits(8);
		if (rd[7:5] == 3'd0)
			rd = 32'd0;  // Writes to r0 now and then
		rs1 = rand_bits(5);
		rs2 = rand_bits(5);
		simm = rand_bits(13);
		issue({2'b10, rd[4:0], 1'b0, cc[0], 1'b0, fn[2:0], rs1[4:0], imm[0],
			imm[0] ? simm[12:0] : {8'd0, rs2[4:0]}}, rd[4:0]);
		model_alu(fn[2:0], m_regs[rs1[4:0]], operand2(imm[0], simm[12:0], rs2[4:0]),
			res, flags);
		write_reg(rd[4:0], res);
		if (cc[0])
			m_icc = flags;
		advance();
		check_state();
	endtask

	task automatic do_branch(input logic [3:0] cond, input logic annul);
		logic [31:0] disp, target, addr;
		disp = rand_bits(22);
		addr = rand_bits(5);
		issue({2'b00, annul, cond, 3'b010, disp[21:0]}, addr[4:0]);
		target = m_pc + {{8{disp[21]}}, disp[21:0], 2'b00};
		if (cond == 4'h8 && annul) begin
			m_pc = target;  // Annulled BA skips the delay slot
			m_npc = target + 32'd4;
		end
		else if (cond_holds(cond, m_icc)) begin
			m_pc = m_npc;
			m_npc = target;
		end
		else if (annul) begin
			m_pc = m_npc + 32'd4;
			m_npc = m_npc + 32'd8;
		end
		else
			advance();
		check_state();
	endtask

	task automatic do_call();
		logic [31:0] disp, target;
		disp = rand_bits(30);
		issue({2'b01, disp[29:0]}, 5'd15);
		target = m_pc + {disp[29:0], 2'b00};
		write_reg(5'd15, m_pc);
		m_pc = m_npc;
		m_npc = target;
		check_state();
	endtask

	task automatic do_jmpl();
		logic [31:0] rd, rs1, rs2, imm, simm, target;
		rd = rand_bits(5);
		rs1 = rand_bits(5);
		rs2 = rand_bits(5);
		imm = rand_bits(1);
		simm = rand_bits(13);
		issue({2'b10, rd[4:0], 6'b111000, rs1[4:0], imm[0],
			imm[0] ? simm[12:0] : {8'd0, rs2[4:0]}}, rd[4:0]);
		write_reg(rd[4:0], m_pc);  // Link lands before rs1 is read
		target = m_regs[rs1[4:0]] + operand2(imm[0], simm[12:0], rs2[4:0]);
		m_pc = m_npc;
		m_npc = target;
		check_state();
	endtask

	// Memory format or an arithmetic op3 outside the kept set
	task automatic do_unsupported();
		logic [31:0] w, addr;
		w = rand_bits(32);
		addr = rand_bits(5);
		w[31] = 1'b1;
		if (!w[30]) begin
			if (!w[24] && !w[22] && w[21:19] <= 3'd4)
				w[22] = 1'b1;
			if (w[24:19] == 6'b111000)
				w[19] = 1'b1;  // Not JMPL
		end
		issue(w, addr[4:0]);
		advance();
		check_state();
	endtask

	initial begin
		logic [31:0] pick;
		logic [31:0] bsel;
		lfsr = 32'd41;
		RESET = 1'b1;
		instr = '0;
		instr_valid = 1'b0;
		dbg_addr = '0;
		repeat (RESET_CYCLES) @(posedge Clk);
		@(negedge Clk);
		RESET = 1'b0;
		for (int i = 0; i < 32; i++)
			m_regs[i[4:0]] = '0;
		m_pc = RESET_PC;
		m_npc = RESET_PC + 32'd4;
		m_icc = '0;
		check_value("busy", {31'd0, busy}, 32'd0);  // Idle straight out of reset
		check_state();
		for (int i = 0; i < N_RANDOM; i++) begin
			pick = rand_bits(3);
			case (pick[2:0])
				3'd0, 3'd1, 3'd2: do_alu();
				3'd3, 3'd4: begin
					bsel = rand_bits(5);  // Condition in the low four bits, annul on top
					do_branch(bsel[3:0], bsel[4]);
				end
				3'd5: do_call();
				3'd6: do_jmpl();
				default: do_unsupported();
			endcase
		end
		// Every condition with and without annul on the flags left by the mix
		for (int c = 0; c < 16; c++) begin
			do_branch(c[3:0], 1'b0);
			do_branch(c[3:0], 1'b1);
		end
		$display("Test passed");
		$finish;
	end

endmodule

// ==== dv/sparc_core_assertions.sv ====
`timescale 1ns/1ps

// Sequencer protocol checks
module sparc_core_assertions (
	input logic Clk,
	input logic RESET,
	input logic instr_valid,
	input logic busy,
	input sparc_pkg::seq_state_t state,
	input logic rf_we,
	input logic pc_en,
	input logic npc_en,
	input logic icc_en
);

	// All enables quiet once reset has been seen
	reset_quiet: assert property (@(posedge Clk)
		RESET |=> !busy && !rf_we && !pc_en && !npc_en && !icc_en)
		else $error("Core busy or enables active after reset");

	// An idle core always takes the strobe
	start_accept: assert property (@(posedge Clk) disable iff (RESET)
		instr_valid && !busy |=> busy)
		else $error("Offered instruction not accepted while idle");

	// Longest class holds busy two cycles, never four
	busy_bounded: assert property (@(posedge Clk) disable iff (RESET)
		!(busy && $past(busy) && $past(busy, 2) && $past(busy, 3)))
		else $error("Busy stayed high longer than three cycles");

	// Register writes only from the link and commit steps
	write_states: assert property (@(posedge Clk) disable iff (RESET)
		rf_we |-> (state == sparc_pkg::LINK || state == sparc_pkg::WRITE))
		else $error("Register write outside LINK or WRITE");

	assert property (@(posedge Clk) disable iff (RESET) pc_en == npc_en)
		else $error("PC and nPC enables out of step");

	assert property (@(posedge Clk) disable iff (RESET) icc_en |-> state == sparc_pkg::WRITE)
		else $error("Flag update outside WRITE");

endmodule

bind control_sequencer sparc_core_assertions u_assertions (
	.Clk(Clk),
	.RESET(RESET),
	.instr_valid(instr_valid),
	.busy(busy),
	.state(state),
	.rf_we(ctrl.rf_we),
	.pc_en(ctrl.pc_en),
	.npc_en(ctrl.npc_en),
	.icc_en(ctrl.icc_en)
);

// ==== rtl/sparc_core.sv ====
`timescale 1ns/1ps

module sparc_core #(
	parameter logic [sparc_pkg::XLEN-1:0] RESET_PC = '0
) (
	input logic Clk,
	input logic RESET,
	input logic [sparc_pkg::XLEN-1:0] instr,
	input logic instr_valid,                        // One-cycle start strobe
	input logic [sparc_pkg::REG_ADDR_W-1:0] dbg_addr,
	output logic busy,
	output logic [sparc_pkg::XLEN-1:0] pc,
	output logic [sparc_pkg::XLEN-1:0] npc,
	output logic [sparc_pkg::ICC_W-1:0] icc,
	output logic [sparc_pkg::XLEN-1:0] dbg_data
);

	logic [sparc_pkg::XLEN-1:0] ir;        // Held instruction
	logic [sparc_pkg::XLEN-1:0] dec_word;
	logic taken;

	decode_if dec_bus ();
	ctrl_if ctrl_bus ();

	// Capture on accept, strobes during busy are dropped
	always_ff @(posedge Clk) begin
		if (instr_valid && !busy)
			ir <= instr;
	end

	// Idle decode looks at the offered word so the sequencer picks its first step
	assign dec_word = busy ? ir : instr;

	instr_decoder u_decoder (.instr(dec_word), .dec(dec_bus.dec));

	branch_cond u_branch_cond (.cond(dec_bus.cond), .icc(ctrl_bus.icc), .taken(taken));

	control_sequencer u_sequencer (
		.Clk(Clk),
		.RESET(RESET),
		.instr_valid(instr_valid),
		.dec(dec_bus.seq),
		.taken(taken),
		.ctrl(ctrl_bus.seq),
		.busy(busy)
	);

	sparc_datapath #(.RESET_PC(RESET_PC)) u_datapath (
		.Clk(Clk),
		.RESET(RESET),
		.ctrl(ctrl_bus.dp),
		.pc(pc),
		.npc(npc),
		.dbg_addr(dbg_addr),
		.dbg_data(dbg_data)
	);

	assign icc = ctrl_bus.icc;

endmodule

// ==== rtl/sparc_datapath.sv ====
`timescale 1ns/1ps

module sparc_datapath #(
	parameter logic [sparc_pkg::XLEN-1:0] RESET_PC = '0
) (
	input logic Clk,
	input logic RESET,
	ctrl_if.dp ctrl,
	output logic [sparc_pkg::XLEN-1:0] pc,
	output logic [sparc_pkg::XLEN-1:0] npc,
	input logic [sparc_pkg::REG_ADDR_W-1:0] dbg_addr,
	output logic [sparc_pkg::XLEN-1:0] dbg_data
);

	localparam int NREGS = 2 ** sparc_pkg::REG_ADDR_W;

	logic [sparc_pkg::XLEN-1:0] regs [NREGS];
	logic [sparc_pkg::XLEN-1:0] rs1_data;
	logic [sparc_pkg::XLEN-1:0] rs2_data;
	logic [sparc_pkg::XLEN-1:0] a_op;
	logic [sparc_pkg::XLEN-1:0] b_op;
	logic [sparc_pkg::XLEN:0] add_res;   // Top bit is carry out
	logic [sparc_pkg::XLEN:0] sub_res;   // Top bit is borrow
	logic [sparc_pkg::XLEN-1:0] alu_res;
	logic alu_v;
	logic alu_c;
	logic [sparc_pkg::XLEN-1:0] pc_next;
	logic [sparc_pkg::XLEN-1:0] npc_next;
	logic [sparc_pkg::ICC_W-1:0] icc_q;

	// Register file, r0 is never written
	always_ff @(posedge Clk) begin
		if (RESET) begin
			for (int i = 0; i < NREGS; i++)
				regs[i] <= '0;
		end
		else if (ctrl.rf_we && ctrl.rd != '0) begin
			regs[ctrl.rd] <= alu_res;
		end
	end

	assign rs1_data = regs[ctrl.rs1];
	assign rs2_data = regs[ctrl.rs2];
	assign dbg_data = regs[dbg_addr];  // Third read port for the testbench

	assign a_op = (ctrl.a_sel == sparc_pkg::A_PC) ? pc : rs1_data;

	// Sign extension and word scaling of the immediates
	always_comb begin
		case (ctrl.b_sel)
			sparc_pkg::B_RS2:    b_op = rs2_data;
			sparc_pkg::B_SIMM13: b_op = {{19{ctrl.imm[12]}}, ctrl.imm};
			sparc_pkg::B_DISP22: b_op = {{8{ctrl.disp[21]}}, ctrl.disp[21:0], 2'b00};
			sparc_pkg::B_DISP30: b_op = {ctrl.disp, 2'b00};  // Wraps, no extension needed
			sparc_pkg::B_FOUR:   b_op = 32'd4;
			default:             b_op = '0;
		endcase
	end

	// ALU with n z v c generation
	always_comb begin
		add_res = {1'b0, a_op} + {1'b0, b_op};
		sub_res = {1'b0, a_op} - {1'b0, b_op};
		alu_v   = 1'b0;  // Logical ops clear v and c
		alu_c   = 1'b0;
		case (ctrl.alu_op)
			sparc_pkg::ADD: begin
				alu_res = add_res[31:0];
				alu_c   = add_res[32];
				alu_v   = (a_op[31] == b_op[31]) && (alu_res[31] != a_op[31]);
			end
			sparc_pkg::SUB: begin
				alu_res = sub_res[31:0];
				alu_c   = sub_res[32];
				alu_v   = (a_op[31] != b_op[31]) && (alu_res[31] != a_op[31]);
			end
			sparc_pkg::AND: alu_res = a_op & b_op;
			sparc_pkg::OR:  alu_res = a_op | b_op;
			default:        alu_res = a_op ^ b_op;  // XOR
		endcase
	end

	// Delayed-branch PC and nPC sources
	always_comb begin
		case (ctrl.npc_sel)
			sparc_pkg::NPC_ALU: begin
				pc_next  = npc;
				npc_next = alu_res;
			end
			sparc_pkg::NPC_PLUS8: begin
				pc_next  = npc + 32'd4;   // Annulled slot skipped
				npc_next = npc + 32'd8;
			end
			sparc_pkg::NPC_TARGET: begin
				pc_next  = alu_res;
				npc_next = alu_res + 32'd4;
			end
			default: begin
				pc_next  = npc;
				npc_next = npc + 32'd4;
			end
		endcase
	end

	always_ff @(posedge Clk) begin
		if (RESET) begin
			pc    <= RESET_PC;
			npc   <= RESET_PC + 32'd4;
			icc_q <= '0;
		end
		else begin
			if (ctrl.pc_en)
				pc <= pc_next;
			if (ctrl.npc_en)
				npc <= npc_next;
			if (ctrl.icc_en)
				icc_q <= {alu_res[31], alu_res == '0, alu_v, alu_c};
		end
	end

	assign ctrl.icc = icc_q;

endmodule

// ==== rtl/control_sequencer.sv ====
`timescale 1ns/1ps

module control_sequencer (
	input logic Clk,
	input logic RESET,
	input logic instr_valid,
	decode_if.seq dec,
	input logic taken,
	ctrl_if.seq ctrl,
	output logic busy
);

	sparc_pkg::seq_state_t state;
	sparc_pkg::seq_state_t next_state;
	logic is_call;
	logic ba_annul;  // BA with a set jumps straight to the target

	assign is_call  = (dec.cls == sparc_pkg::CALL);
	assign ba_annul = (dec.cond == sparc_pkg::COND_BA) && dec.annul;
	assign busy     = (state != sparc_pkg::IDLE);

	always_ff @(posedge Clk) begin
		if (RESET)
			state <= sparc_pkg::IDLE;
		else
			state <= next_state;
	end

	// While idle the decoder sees the offered word, so the first step is known on accept
	always_comb begin
		next_state = sparc_pkg::IDLE;
		case (state)
			sparc_pkg::IDLE: begin
				if (instr_valid && (is_call || dec.cls == sparc_pkg::JMPL))
					next_state = sparc_pkg::LINK;
				else if (instr_valid)
					next_state = sparc_pkg::EXEC;
			end
			sparc_pkg::EXEC: begin
				if (dec.cls == sparc_pkg::ALU)
					next_state = sparc_pkg::WRITE;  // Branch and unsupported end here
			end
			sparc_pkg::LINK: next_state = sparc_pkg::JUMP;
			default: next_state = sparc_pkg::IDLE;   // JUMP and WRITE finish
		endcase
	end

	always_comb begin
		// Defaults follow the decode, enables stay off
		ctrl.rf_we  = 1'b0;
		ctrl.rd     = dec.rd;
		ctrl.rs1    = dec.rs1;
		ctrl.rs2    = dec.rs2;
		ctrl.alu_op = dec.alu_op;
		ctrl.a_sel  = sparc_pkg::A_RS1;
		if (dec.use_imm)
			ctrl.b_sel = sparc_pkg::B_SIMM13;
		else
			ctrl.b_sel = sparc_pkg::B_RS2;
		ctrl.imm     = dec.simm13;
		ctrl.disp    = is_call ? dec.disp30 : {8'b0, dec.disp22};
		ctrl.pc_en   = 1'b0;
		ctrl.npc_en  = 1'b0;
		ctrl.npc_sel = sparc_pkg::NPC_PLUS4;
		ctrl.icc_en  = 1'b0;

		case (state)
			sparc_pkg::EXEC: begin
				if (dec.cls == sparc_pkg::BRANCH) begin
					ctrl.alu_op = sparc_pkg::ADD;  // PC + 4*disp22
					ctrl.a_sel  = sparc_pkg::A_PC;
					ctrl.b_sel  = sparc_pkg::B_DISP22;
					ctrl.pc_en  = 1'b1;
					ctrl.npc_en = 1'b1;
					if (taken && ba_annul)
						ctrl.npc_sel = sparc_pkg::NPC_TARGET;
					else if (taken)
						ctrl.npc_sel = sparc_pkg::NPC_ALU;   // Delay slot runs
					else if (dec.annul)
						ctrl.npc_sel = sparc_pkg::NPC_PLUS8; // Skip the delay slot
				end
				else if (dec.cls == sparc_pkg::UNSUPPORTED) begin
					ctrl.pc_en  = 1'b1;  // Sequential advance only
					ctrl.npc_en = 1'b1;
				end
				// ALU group only settles its operands here
			end
			sparc_pkg::WRITE: begin
				ctrl.rf_we  = 1'b1;
				ctrl.icc_en = dec.set_cc;
				ctrl.pc_en  = 1'b1;
				ctrl.npc_en = 1'b1;
			end
			sparc_pkg::LINK: begin
				// PC + r0 into the link register
				ctrl.alu_op = sparc_pkg::ADD;
				ctrl.a_sel  = sparc_pkg::A_PC;
				ctrl.b_sel  = sparc_pkg::B_RS2;
				ctrl.rs2    = '0;
				ctrl.rf_we  = 1'b1;
				if (is_call)
					ctrl.rd = sparc_pkg::LINK_REG;
			end
			sparc_pkg::JUMP: begin
				// JMPL reads rs1 after the link write, as the reference control does
				ctrl.alu_op  = sparc_pkg::ADD;
				ctrl.pc_en   = 1'b1;
				ctrl.npc_en  = 1'b1;
				ctrl.npc_sel = sparc_pkg::NPC_ALU;
				if (is_call) begin
					ctrl.a_sel = sparc_pkg::A_PC;     // PC still holds the CALL address
					ctrl.b_sel = sparc_pkg::B_DISP30;
				end
			end
			default: ;
		endcase
	end

endmodule

// ==== rtl/branch_cond.sv ====
`timescale 1ns/1ps

module branch_cond (
	input logic [sparc_pkg::COND_W-1:0] cond,
	input logic [sparc_pkg::ICC_W-1:0] icc,
	output logic taken
);

	logic n;
	logic z;
	logic v;
	logic c;
	logic base;  // Lower eight conditions, the upper eight invert them

	assign n = icc[3];
	assign z = icc[2];
	assign v = icc[1];
	assign c = icc[0];

	always_comb begin
		case (cond[2:0])
			3'd0: base = 1'b0;             // BN, BA when inverted
			3'd1: base = z;                // BE / BNE
			3'd2: base = z | (n ^ v);      // BLE / BG
			3'd3: base = n ^ v;            // BL / BGE
			3'd4: base = c | z;            // BLEU / BGU
			3'd5: base = c;                // BCS / BCC
			3'd6: base = n;                // BNEG / BPOS
			default: base = v;             // BVS / BVC
		endcase
	end

	// cond[3] selects the complementary condition
	assign taken = base ^ cond[3];

endmodule

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
	input logic [sparc_pkg::XLEN-1:0] instr,
	decode_if.dec dec
);

	logic [5:0] op3;
	logic op3_kept;  // ADD AND OR XOR SUB and their cc forms

	assign op3 = instr[24:19];

	// op3 of the kept group is 0c0xxx with xxx from 0 to 4
	assign op3_kept = !op3[5] && !op3[3] && (op3[2:0] <= 3'd4);

	// Instruction group from the format field, then op3
	always_comb begin
		case (instr[31:30])
			sparc_pkg::OP_BRANCH: dec.cls = sparc_pkg::BRANCH;
			sparc_pkg::OP_CALL:   dec.cls = sparc_pkg::CALL;
			sparc_pkg::OP_ARITH: begin
				if (op3 == sparc_pkg::OP3_JMPL)
					dec.cls = sparc_pkg::JMPL;
				else if (op3_kept)
					dec.cls = sparc_pkg::ALU;
				else
					dec.cls = sparc_pkg::UNSUPPORTED;  // SAVE, RESTORE, WRTBR and the rest
			end
			default: dec.cls = sparc_pkg::UNSUPPORTED;  // Loads, stores, SWAP
		endcase
	end

	// Low op3 bits are the ALU function itself
	always_comb begin
		if (op3_kept)
			dec.alu_op = sparc_pkg::alu_op_t'(op3[2:0]);
		else
			dec.alu_op = sparc_pkg::ADD;  // JMPL and links only add
	end

	// Register fields
	assign dec.rd      = instr[29:25];
	assign dec.rs1     = instr[18:14];
	assign dec.rs2     = instr[4:0];
	assign dec.use_imm = instr[13];
	assign dec.set_cc  = op3[4];

	// Branch fields overlap rd
	assign dec.annul = instr[29];
	assign dec.cond  = instr[28:25];

	// Raw immediates, extension happens in the datapath
	assign dec.simm13 = instr[12:0];
	assign dec.disp22 = instr[21:0];
	assign dec.disp30 = instr[29:0];

endmodule

// ==== rtl/sparc_ifs.sv ====
`timescale 1ns/1ps

// Decoded fields of the held instruction, no state inside
interface decode_if;
	sparc_pkg::instr_class_t cls;
	logic [sparc_pkg::REG_ADDR_W-1:0] rd;
	logic [sparc_pkg::REG_ADDR_W-1:0] rs1;
	logic [sparc_pkg::REG_ADDR_W-1:0] rs2;
	logic use_imm;                           // i bit
	logic annul;                             // a bit of Bicc
	logic [sparc_pkg::COND_W-1:0] cond;
	sparc_pkg::alu_op_t alu_op;
	logic set_cc;                            // cc variant of the ALU op
	logic [sparc_pkg::SIMM_W-1:0] simm13;    // Raw, not extended
	logic [sparc_pkg::DISP22_W-1:0] disp22;
	logic [sparc_pkg::DISP30_W-1:0] disp30;

	modport dec (
		output cls, rd, rs1, rs2, use_imm, annul, cond, alu_op, set_cc,
		output simm13, disp22, disp30
	);
	modport seq (
		input cls, rd, rs1, rs2, use_imm, annul, cond, alu_op, set_cc,
		input simm13, disp22, disp30
	);
endinterface

// Per-cycle datapath controls, flags come back the other way
interface ctrl_if;
	logic rf_we;
	logic [sparc_pkg::REG_ADDR_W-1:0] rd;
	logic [sparc_pkg::REG_ADDR_W-1:0] rs1;
	logic [sparc_pkg::REG_ADDR_W-1:0] rs2;
	sparc_pkg::alu_op_t alu_op;
	sparc_pkg::a_sel_t a_sel;
	sparc_pkg::b_sel_t b_sel;
	logic [sparc_pkg::SIMM_W-1:0] imm;
	logic [sparc_pkg::DISP30_W-1:0] disp;    // disp22 sits in the low bits for Bicc
	logic pc_en;
	logic npc_en;
	sparc_pkg::npc_sel_t npc_sel;
	logic icc_en;
	logic [sparc_pkg::ICC_W-1:0] icc;        // Current flags from the datapath

	modport seq (
		output rf_we, rd, rs1, rs2, alu_op, a_sel, b_sel, imm, disp,
		output pc_en, npc_en, npc_sel, icc_en
	);
	modport dp (
		input rf_we, rd, rs1, rs2, alu_op, a_sel, b_sel, imm, disp,
		input pc_en, npc_en, npc_sel, icc_en,
		output icc
	);
endinterface

// ==== rtl/sparc_pkg.sv ====
package sparc_pkg;

	// Field widths
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int COND_W     = 4;
	localparam int ICC_W      = 4;  // Order is n z v c, n at the top
	localparam int SIMM_W     = 13;
	localparam int DISP22_W   = 22;
	localparam int DISP30_W   = 30;

	// CALL leaves its return address here
	localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd15;

	// Format field in bits 31:30
	localparam logic [1:0] OP_BRANCH = 2'b00;
	localparam logic [1:0] OP_CALL   = 2'b01;
	localparam logic [1:0] OP_ARITH  = 2'b10;  // 2'b11 is memory, not kept

	localparam logic [5:0] OP3_JMPL = 6'b111000;
	localparam logic [COND_W-1:0] COND_BA = 4'b1000;  // Branch always

	typedef enum logic [2:0] {
		BRANCH,
		CALL,
		JMPL,
		ALU,
		UNSUPPORTED
	} instr_class_t;

	// Values equal op3[2:0] of the kept arithmetic and logic group
	typedef enum logic [2:0] {
		ADD = 3'b000,
		AND = 3'b001,
		OR  = 3'b010,
		XOR = 3'b011,
		SUB = 3'b100
	} alu_op_t;

	typedef enum logic [2:0] {IDLE, EXEC, LINK, JUMP, WRITE} seq_state_t;

	typedef enum logic {A_RS1, A_PC} a_sel_t;

	typedef enum logic [2:0] {B_RS2, B_SIMM13, B_DISP22, B_DISP30, B_FOUR} b_sel_t;

	// NPC_TARGET moves PC to the ALU target as well, for annulled BA
	typedef enum logic [1:0] {NPC_PLUS4, NPC_ALU, NPC_PLUS8, NPC_TARGET} npc_sel_t;

endpackage
